// ==== compile.f ====
rtl/corr_pkg.sv
rtl/sample_align.sv
rtl/carrier_nco.sv
rtl/carrier_wipe.sv
rtl/code_accum.sv
rtl/subchannel.sv
dv/subchannel_tb.sv

// ==== Makefile ====
TOP = subchannel_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// ==== dv/subchannel_tb.sv ====
`timescale 1ns/1ps

module subchannel_tb import corr_pkg::*; ();

   localparam int RESET_CYCLES = 16;
   localparam int MAX_DUMPS    = 256;
   // Worst-case cycles per test, gaps of up to 7 idle cycles in the last one
   localparam int TEST_CYCLES    = 20 + 64 + 256 + 48 + 6 * 16 * 8;
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + TEST_CYCLES + 200;

   logic     clk;
   logic     reset_i;
   logic     sample_valid_i;
   sample_t  sample_i;
   logic     chip_i;
   logic     dump_i;
   doppler_t doppler_i;
   logic     dump_valid_o;
   acc_t     acc_i_o;
   acc_t     acc_q_o;
   logic     dump_strobe;

   // Reference model state
   phase_t model_phase;
   acc_t   model_i;
   acc_t   model_q;
   acc_t   exp_i_mem [0:MAX_DUMPS-1];
   acc_t   exp_q_mem [0:MAX_DUMPS-1];
   acc_t   exp_i_head;
   acc_t   exp_q_head;
   int     dump_count;
   int     check_index;

   int          error_count;
   int          test_num;
   int          tests_passed;
   int          tests_failed;
   int          cycle_count;
   logic [31:0] lfsr_state;

   subchannel subchannel_inst (
      .clk            (clk),
      .reset_i        (reset_i),
      .sample_valid_i (sample_valid_i),
      .sample_i       (sample_i),
      .chip_i         (chip_i),
      .dump_i         (dump_i),
      .doppler_i      (doppler_i),
      .dump_valid_o   (dump_valid_o),
      .acc_i_o        (acc_i_o),
      .acc_q_o        (acc_q_o)
   );

   always #5 clk = ~clk;

   assign dump_strobe = sample_valid_i & dump_i;
   // Expected sums of the dump currently on the outputs
   assign exp_i_head = exp_i_mem[check_index];
   assign exp_q_head = exp_q_mem[check_index];

   // Counts finished dump pulses, stable between rising edges
   always_ff @(posedge clk) begin
      if (reset_i) begin
         check_index <= 0;
      end else if (dump_valid_o) begin
         check_index <= check_index + 1;
      end
   end

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] random_bits(input int count);
      logic [31:0] value;
      value = '0;
      for (int k = 0; k < count; k++) begin
         lfsr_state = lfsr_step(lfsr_state);
         value = {value[30:0], lfsr_state[0]};
      end
      return value;
   endfunction

   // Carrier and accumulation rules applied to one driven sample
   task automatic model_sample(input sample_t s, input logic c, input logic d,
                               input doppler_t dop);
      logic [CARRIER_INDEX_WIDTH-1:0] cos_idx;
      logic [CARRIER_INDEX_WIDTH-1:0] sin_idx;
      int prod_i;
      int prod_q;
      int dop_int;
      // Table entry from the phase before this sample
      cos_idx = model_phase[PHASE_WIDTH-1 -: CARRIER_INDEX_WIDTH];
      // Sine sits a quarter table behind, wrapping mod 16
      sin_idx = cos_idx - 4'd4;
      prod_i = int'(s) * int'(COS_TABLE[cos_idx]);
      prod_q = int'(s) * int'(COS_TABLE[sin_idx]);
      // Chip 0 stands for -1
      if (!c) begin
         prod_i = -prod_i;
         prod_q = -prod_q;
      end
      model_i = model_i + acc_t'(prod_i);
      model_q = model_q + acc_t'(prod_q);
      dop_int = int'(dop);
      if (HIGH_SIDE_MIX) begin
         model_phase = model_phase + F_IF_INC - phase_t'(dop_int);
      end else begin
         model_phase = model_phase + F_IF_INC + phase_t'(dop_int);
      end
      // Dump sample is part of the total, then the sums restart
      if (d) begin
         exp_i_mem[dump_count] = model_i;
         exp_q_mem[dump_count] = model_q;
         dump_count = dump_count + 1;
         model_i = '0;
         model_q = '0;
      end
   endtask

   task automatic send_sample(input sample_t s, input logic c, input logic d,
                              input doppler_t dop);
      @(negedge clk);
      sample_valid_i = 1'b1;
      sample_i = s;
      chip_i = c;
      dump_i = d;
      doppler_i = dop;
      model_sample(s, c, d, dop);
   endtask

   // Strobe low, optionally with junk on the other inputs
   task automatic idle_cycles(input int count, input logic scramble);
      for (int k = 0; k < count; k++) begin
         @(negedge clk);
         sample_valid_i = 1'b0;
         if (scramble) begin
            sample_i = sample_t'(random_bits(3));
            chip_i = 1'(random_bits(1));
            dump_i = 1'(random_bits(1));
            doppler_i = doppler_t'(random_bits(12));
         end
      end
   endtask

   // Waits until every queued dump has been seen, the cycle limit guards it
   task automatic wait_results();
      while (check_index != dump_count) begin
         @(negedge clk);
      end
   endtask

   task automatic finish_test(input string name, input int errors_before);
      if (error_count == errors_before) begin
         tests_passed = tests_passed + 1;
         $display("Test %0d %s: passed", test_num, name);
      end else begin
         tests_failed = tests_failed + 1;
         $display("Test %0d %s: FAILED with %0d errors", test_num, name,
                  error_count - errors_before);
      end
   endtask

   // Both sums against the model at each dump pulse
   sums_match_a : assert property (
      @(negedge clk) disable iff (reset_i)
      dump_valid_o |-> (acc_i_o == exp_i_head) && (acc_q_o == exp_q_head)
   ) else begin
      error_count = error_count + 1;
      $display("** Error at %0t: dump %0d gave I=%0d Q=%0d, expected I=%0d Q=%0d",
               $time, check_index, acc_i_o, acc_q_o, exp_i_head, exp_q_head);
   end

   // Pulse exactly 3 cycles after a dump strobe and at no other time
   dump_delay_a : assert property (
      @(posedge clk) disable iff (reset_i)
      dump_valid_o == $past(dump_strobe, 3)
   ) else begin
      error_count = error_count + 1;
      $display("At %0t dump_valid_o did not follow its dump strobe by 3 cycles", $time);
   end

   // Outputs only move on a dump
   acc_hold_a : assert property (
      @(posedge clk) disable iff (reset_i)
      !dump_valid_o |-> $stable(acc_i_o) && $stable(acc_q_o)
   ) else begin
      error_count = error_count + 1;
      $display("At %0t the sums changed without a dump pulse", $time);
   end

   quiet_start_a : assert property (
      @(posedge clk) disable iff (reset_i)
      (check_index == 0 && !dump_valid_o) |-> (acc_i_o == '0) && (acc_q_o == '0)
   ) else begin
      error_count = error_count + 1;
      $display("** Error at %0t: outputs not zero before the first dump", $time);
   end

   // Phase pinned at 0 puts a zero on the sine branch
   zero_phase_q_a : assert property (
      @(negedge clk) disable iff (reset_i)
      (test_num == 2 && dump_valid_o) |-> (acc_q_o == '0)
   ) else begin
      error_count = error_count + 1;
      $display("** Error at %0t: Q sum %0d at zero phase", $time, acc_q_o);
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Run timed out after %0d cycles without finishing", TIMEOUT_CYCLES);
         $display("Test failures found");
         $finish;
      end
   end

   initial begin
      int       errors_before;
      int       length;
      doppler_t dop;
      clk = 1'b0;
      reset_i = 1'b1;
      sample_valid_i = 1'b0;
      sample_i = '0;
      chip_i = 1'b0;
      dump_i = 1'b0;
      doppler_i = '0;
      model_phase = '0;
      model_i = '0;
      model_q = '0;
      dump_count = 0;
      error_count = 0;
      test_num = 0;
      tests_passed = 0;
      tests_failed = 0;
      cycle_count = 0;
      lfsr_state = 32'h7868;
      repeat (RESET_CYCLES) @(negedge clk);
      reset_i = 1'b0;

      // No strobes at all
      test_num = 1;
      errors_before = error_count;
      idle_cycles(20, 1'b0);
      finish_test("idle after reset", errors_before);

      // Doppler cancels the IF step so the phase stays at 0
      test_num = 2;
      errors_before = error_count;
      dop = doppler_t'(-int'(F_IF_INC));
      for (int p = 0; p < 4; p++) begin
         for (int n = 0; n < 16; n++) begin
            send_sample(sample_t'(random_bits(3)), 1'(random_bits(1)), n == 15, dop);
         end
      end
      idle_cycles(1, 1'b0);
      wait_results();
      finish_test("fixed carrier phase", errors_before);

      // Rotating carrier, one random nonzero Doppler per period
      test_num = 3;
      errors_before = error_count;
      for (int p = 0; p < 8; p++) begin
         length = 1 + int'(random_bits(5));
         dop = doppler_t'(random_bits(12));
         if (dop == '0) begin
            dop = 12'sd1;
         end
         for (int n = 0; n < length; n++) begin
            send_sample(sample_t'(random_bits(3)), 1'(random_bits(1)), n == length - 1, dop);
         end
      end
      idle_cycles(1, 1'b0);
      wait_results();
      finish_test("random doppler", errors_before);

      // Dumps on consecutive strobes, one-sample periods first
      test_num = 4;
      errors_before = error_count;
      dop = doppler_t'(random_bits(12));
      for (int n = 0; n < 48; n++) begin
         send_sample(sample_t'(random_bits(3)), 1'(random_bits(1)),
                     (n < 3) || (n == 47) || (random_bits(1) == 1), dop);
      end
      idle_cycles(1, 1'b0);
      wait_results();
      finish_test("back-to-back dumps", errors_before);

      // Random idle gaps with junk inputs between strobes
      test_num = 5;
      errors_before = error_count;
      for (int p = 0; p < 6; p++) begin
         length = 1 + int'(random_bits(4));
         for (int n = 0; n < length; n++) begin
            idle_cycles(int'(random_bits(3)), 1'b1);
            send_sample(sample_t'(random_bits(3)), 1'(random_bits(1)), n == length - 1,
                        doppler_t'(random_bits(12)));
         end
      end
      idle_cycles(1, 1'b0);
      wait_results();
      finish_test("idle gaps", errors_before);

      idle_cycles(4, 1'b0);
      $display("Tests passed: %0d, failed: %0d, assertion errors: %0d",
               tests_passed, tests_failed, error_count);
      if (tests_failed == 0 && error_count == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// ==== rtl/subchannel.sv ====
`timescale 1ns/1ps

module subchannel import corr_pkg::*; (
   input  logic     clk,
   input  logic     reset_i,
   input  logic     sample_valid_i,
   input  sample_t  sample_i,
   input  logic     chip_i,
   input  logic     dump_i,
   input  doppler_t doppler_i,
   output logic     dump_valid_o,
   output acc_t     acc_i_o,
   output acc_t     acc_q_o
);

   aligned_s aligned;
   mixed_s   mixed;
   doppler_t doppler_q;
   carrier_t carrier_i;
   carrier_t carrier_q;

   // Doppler taken with the strobe, so the NCO steps with the aligned sample's word
   always_ff @(posedge clk) begin
      if (sample_valid_i) begin
         doppler_q <= doppler_i;
      end
   end

   // Input side
   sample_align sample_align_inst (
      .clk            (clk),
      .reset_i        (reset_i),
      .sample_valid_i (sample_valid_i),
      .sample_i       (sample_i),
      .chip_i         (chip_i),
      .dump_i         (dump_i),
      .aligned_o      (aligned)
   );

   // Carrier oscillator steps after the aligned sample has used the current phase
   carrier_nco carrier_nco_inst (
      .clk         (clk),
      .reset_i     (reset_i),
      .step_i      (aligned.valid),
      .doppler_i   (doppler_q),
      .carrier_i_o (carrier_i),
      .carrier_q_o (carrier_q)
   );

   carrier_wipe carrier_wipe_inst (
      .clk         (clk),
      .reset_i     (reset_i),
      .aligned_i   (aligned),
      .carrier_i_i (carrier_i),
      .carrier_q_i (carrier_q),
      .mixed_o     (mixed)
   );

   // Output side
   code_accum code_accum_inst (
      .clk          (clk),
      .reset_i      (reset_i),
      .mixed_i      (mixed),
      .dump_valid_o (dump_valid_o),
      .acc_i_o      (acc_i_o),
      .acc_q_o      (acc_q_o)
   );

endmodule

// ==== rtl/code_accum.sv ====
`timescale 1ns/1ps

module code_accum import corr_pkg::*; (
   input  logic   clk,
   input  logic   reset_i,
   input  mixed_s mixed_i,
   output logic   dump_valid_o,
   output acc_t   acc_i_o,
   output acc_t   acc_q_o
);

   acc_t sum_i_q;
   acc_t sum_q_q;
   acc_t next_i;
   acc_t next_q;

   // Code wipe-off
   // Chip 1 passes the product, chip 0 negates it
   function automatic acc_t wipe_code(input product_t prod, input logic chip);
      acc_t ext;
      ext = {{(ACC_WIDTH-PRODUCT_WIDTH){prod[PRODUCT_WIDTH-1]}}, prod};
      return chip ? ext : -ext;
   endfunction

   // Running sums including the incoming sample, two's complement wrap
   assign next_i = sum_i_q + wipe_code(mixed_i.prod_i, mixed_i.chip);
   assign next_q = sum_q_q + wipe_code(mixed_i.prod_q, mixed_i.chip);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         sum_i_q      <= '0;
         sum_q_q      <= '0;
         acc_i_o      <= '0;
         acc_q_o      <= '0;
         dump_valid_o <= 1'b0;
      end else begin
         dump_valid_o <= mixed_i.valid & mixed_i.dump;
         if (mixed_i.valid) begin
            if (mixed_i.dump) begin
               // Dump sample closes the period
               // Report the total and start the next period from zero
               acc_i_o <= next_i;
               acc_q_o <= next_q;
               sum_i_q <= '0;
               sum_q_q <= '0;
            end else begin
               sum_i_q <= next_i;
               sum_q_q <= next_q;
            end
         end
      end
   end

   // Back-to-back dump pulses only for one-sample integrations
   dump_pulse_a : assert property (
      @(posedge clk) disable iff (reset_i)
      dump_valid_o ##1 dump_valid_o |->
         $past(mixed_i.valid && mixed_i.dump, 1) &&
         $past(mixed_i.valid && mixed_i.dump, 2)
   ) else $error("dump_valid_o held without consecutive dumps");

endmodule

// ==== rtl/carrier_wipe.sv ====
`timescale 1ns/1ps

module carrier_wipe import corr_pkg::*; (
   input  logic     clk,
   input  logic     reset_i,
   input  aligned_s aligned_i,
   input  carrier_t carrier_i_i,
   input  carrier_t carrier_q_i,
   output mixed_s   mixed_o
);

   // One guard bit above the product type to catch overflow
   logic signed [PRODUCT_WIDTH:0] prod_i_full;
   logic signed [PRODUCT_WIDTH:0] prod_q_full;

   // Signed sample times signed carrier, both branches
   assign prod_i_full = $signed(aligned_i.sample) * $signed(carrier_i_i);
   assign prod_q_full = $signed(aligned_i.sample) * $signed(carrier_q_i);

   // Stage control
   always_ff @(posedge clk) begin
      if (reset_i) begin
         mixed_o.valid <= 1'b0;
         mixed_o.dump  <= 1'b0;
      end else begin
         mixed_o.valid <= aligned_i.valid;
         mixed_o.dump  <= aligned_i.valid & aligned_i.dump;
      end
   end

   // Products and chip move on together
   always_ff @(posedge clk) begin
      mixed_o.prod_i <= prod_i_full[PRODUCT_WIDTH-1:0];
      mixed_o.prod_q <= prod_q_full[PRODUCT_WIDTH-1:0];
      mixed_o.chip   <= aligned_i.chip;
   end

   // Truncation to product_t must be lossless for every table entry
   prod_fits_a : assert property (
      @(posedge clk) disable iff (reset_i)
      aligned_i.valid |->
         (prod_i_full == $signed(prod_i_full[PRODUCT_WIDTH-1:0])) &&
         (prod_q_full == $signed(prod_q_full[PRODUCT_WIDTH-1:0]))
   ) else $error("carrier product overflows product width");

endmodule

// ==== rtl/carrier_nco.sv ====
`timescale 1ns/1ps

module carrier_nco import corr_pkg::*; (
   input  logic     clk,
   input  logic     reset_i,
   input  logic     step_i,
   input  doppler_t doppler_i,
   output carrier_t carrier_i_o,
   output carrier_t carrier_q_o
);

   localparam int PAD_WIDTH = PHASE_WIDTH - DOPPLER_WIDTH;
   // Quarter cycle in table steps
   localparam int QUARTER = 2 ** (CARRIER_INDEX_WIDTH - 2);

   phase_t phase_q;
   phase_t doppler_ext;
   phase_t phase_inc;

   logic [CARRIER_INDEX_WIDTH-1:0] cos_index;
   logic [CARRIER_INDEX_WIDTH-1:0] sin_index;

   // Sign-extend the two's complement Doppler word to the phase width
   assign doppler_ext = {{PAD_WIDTH{doppler_i[DOPPLER_WIDTH-1]}}, doppler_i};

   // High-side mixing flips the sense of the Doppler shift
   assign phase_inc = HIGH_SIDE_MIX ? (F_IF_INC - doppler_ext)
                                    : (F_IF_INC + doppler_ext);

   // Phase accumulator
   // Advances once per sample and wraps freely, a dump never touches it
   always_ff @(posedge clk) begin
      if (reset_i) begin
         phase_q <= '0;
      end else if (step_i) begin
         phase_q <= phase_q + phase_inc;
      end
   end

   // Table index from the top phase bits
   assign cos_index = phase_q[PHASE_WIDTH-1 -: CARRIER_INDEX_WIDTH];

   // sin(x) = cos(x - 90 deg), index wraps modulo the table size
   assign sin_index = cos_index - CARRIER_INDEX_WIDTH'(QUARTER);

   // Lookups are combinational from the phase held before this sample's step
   assign carrier_i_o = COS_TABLE[cos_index];
   assign carrier_q_o = COS_TABLE[sin_index];

endmodule

// ==== rtl/sample_align.sv ====
`timescale 1ns/1ps

module sample_align import corr_pkg::*; (
   input  logic     clk,
   input  logic     reset_i,
   input  logic     sample_valid_i,
   input  sample_t  sample_i,
   input  logic     chip_i,
   input  logic     dump_i,
   output aligned_s aligned_o
);

   // Strobe and dump marker are control, cleared by reset
   always_ff @(posedge clk) begin
      if (reset_i) begin
         aligned_o.valid <= 1'b0;
         aligned_o.dump  <= 1'b0;
      end else begin
         aligned_o.valid <= sample_valid_i;
         // Dump only counts when it rides on a strobe
         aligned_o.dump  <= sample_valid_i & dump_i;
      end
   end

   // Sample and chip are payload
   // They line up with the NCO phase one cycle after the strobe
   always_ff @(posedge clk) begin
      aligned_o.sample <= sample_i;
      aligned_o.chip   <= chip_i;
   end

   // A registered dump must belong to a registered sample
   // Otherwise the integration would close without its last sample
   dump_needs_valid_a : assert property (
      @(posedge clk) disable iff (reset_i)
      aligned_o.dump |-> aligned_o.valid
   ) else $error("aligned dump without valid sample");

endmodule

// ==== rtl/corr_pkg.sv ====
package corr_pkg;

   // Bit widths along the correlator path
   localparam int SAMPLE_WIDTH        = 3;
   localparam int DOPPLER_WIDTH       = 12;
   localparam int PHASE_WIDTH         = 16;
   localparam int CARRIER_WIDTH       = 4;
   localparam int PRODUCT_WIDTH       = SAMPLE_WIDTH + CARRIER_WIDTH;
   localparam int ACC_WIDTH           = 20;
   localparam int CARRIER_INDEX_WIDTH = 4;

   typedef logic signed [SAMPLE_WIDTH-1:0]  sample_t;
   typedef logic signed [DOPPLER_WIDTH-1:0] doppler_t;
   typedef logic        [PHASE_WIDTH-1:0]   phase_t;
   typedef logic signed [CARRIER_WIDTH-1:0] carrier_t;
   typedef logic signed [PRODUCT_WIDTH-1:0] product_t;
   typedef logic signed [ACC_WIDTH-1:0]     acc_t;

   // Nominal IF step per sample, small enough for the Doppler word to cancel it
   localparam phase_t F_IF_INC = 16'h0600;

   // Low-side mixing, Doppler added to the IF step
   localparam logic HIGH_SIDE_MIX = 1'b0;

   // One cosine cycle over 16 phase steps, amplitude 7
   localparam carrier_t COS_TABLE [0:(2**CARRIER_INDEX_WIDTH)-1] = '{
      4'sd7, 4'sd6, 4'sd5, 4'sd3, 4'sd0, -4'sd3, -4'sd5, -4'sd6,
      -4'sd7, -4'sd6, -4'sd5, -4'sd3, 4'sd0, 4'sd3, 4'sd5, 4'sd6
   };

   // Sample as it leaves the input registers
   typedef struct packed {
      logic    valid;
      sample_t sample;
      logic    chip;
      logic    dump;
   } aligned_s;

   // Carrier-wiped sample pair on its way to the accumulators
   typedef struct packed {
      logic     valid;
      product_t prod_i;
      product_t prod_q;
      logic     chip;
      logic     dump;
   } mixed_s;

endpackage
